//--- Makefile
# Verilator build and run for the acquisition path testbench
# pass is decided by the pass message in the simulation output

VERILATOR ?= verilator
TOP       ?= acq_tb
FILELIST  ?= acq_top.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- acq_top.f
+incdir+include
source/acq_pkg.sv
source/adc_frontend.sv
source/acq_trigger.sv
source/acq_timer.sv
source/acq_fsm.sv
source/acq_buffer.sv
source/acq_top.sv
testbench/acq_checker.sv
testbench/acq_tb.sv

//--- include/acq_defines.svh
// acquisition path sizing, shared by the package and the RTL
// buffer depth must be a power of two and equal 2**ACQ_CNT_W
// pre-trigger length must stay below the buffer depth

`ifndef ACQ_DEFINES_SVH
`define ACQ_DEFINES_SVH

// number of ADC channels, one acquisition slice each
`define ACQ_CHN 2

// ADC word and sample width
`define ACQ_SMP_W 16

// samples in one frozen window
`define ACQ_BUF_DEPTH 64

// samples stored ahead of the trigger sample
`define ACQ_PRE_LEN 16

// pointer width, log2 of the buffer depth
`define ACQ_CNT_W 6

`endif

//--- source/acq_buffer.sv
// circular sample memory with a four-phase host readout
// the host must only request while the window is frozen
// first read after freeze returns the oldest sample, reads wrap at the depth

`include "acq_defines.svh"

module acq_buffer (
  input  logic              adc_clk,
  input  logic              top_rst,
  // write side
  input  acq_pkg::smp_t     smp_i,
  input  logic              wr_ena_i,
  input  logic              freeze_i,
  // readout port
  input  acq_pkg::rd_req_t  rd_req_i,
  output acq_pkg::rd_rsp_t  rd_rsp_o,
  output logic              rd_busy_o
);

  // sample memory
  acq_pkg::smp_t mem [`ACQ_BUF_DEPTH];

  logic [`ACQ_CNT_W-1:0] wr_ptr;
  logic [`ACQ_CNT_W-1:0] rd_ptr;
  logic                  rd_ack;
  acq_pkg::smp_t         rd_dat;

  ////////////////////
  // write side
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (wr_ena_i) begin
      mem[wr_ptr] <= smp_i;
    end
  end

  // pointer wraps with the depth
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      wr_ptr <= '0;
    end else if (wr_ena_i) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  ////////////////////
  // readout
  ////////////////////

  // next write slot is the oldest sample once frozen
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rd_ptr <= '0;
    end else if (freeze_i) begin
      rd_ptr <= wr_ptr;
    end else if (rd_ack && !rd_req_i.req) begin
      // req dropped, step to the next sample
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // ack follows req with one cycle of latency
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rd_ack <= 1'b0;
    end else if (!rd_ack && rd_req_i.req) begin
      rd_ack <= 1'b1;
    end else if (rd_ack && !rd_req_i.req) begin
      rd_ack <= 1'b0;
    end
  end

  // registered memory read, valid with ack
  always_ff @(posedge adc_clk) begin
    if (!rd_ack && rd_req_i.req) begin
      rd_dat <= mem[rd_ptr];
    end
  end

  assign rd_rsp_o.ack = rd_ack;
  assign rd_rsp_o.dat = rd_dat;

  // busy from request until ack is back low
  assign rd_busy_o = rd_req_i.req || rd_ack;

endmodule

//--- source/acq_fsm.sv
// acquisition sequencer for one channel
// stop wins over every other input, start is ignored while busy
// window is pre_len samples, the trigger sample, then the rest of the depth
// events are registered, one cycle after the deciding sample

`include "acq_defines.svh"

module acq_fsm (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // software control and stream valid
  input  acq_pkg::acq_ctl_t     ctl_i,
  input  logic                  vld_i,
  // trigger and timer feedback
  input  logic                  hit_i,
  input  logic                  tmr_zero_i,
  // timer control
  output logic                  tmr_load_o,
  output logic [`ACQ_CNT_W:0]   tmr_val_o,
  output logic                  tmr_ena_o,
  // data path control
  output logic                  trg_ena_o,
  output logic                  wr_ena_o,
  output logic                  freeze_o,
  // status and events
  output acq_pkg::acq_sts_t     sts_o,
  output acq_pkg::acq_evn_t     evn_o
);

  localparam logic [`ACQ_CNT_W:0] pre_len  = `ACQ_PRE_LEN;
  localparam logic [`ACQ_CNT_W:0] post_len = `ACQ_BUF_DEPTH - `ACQ_PRE_LEN - 1;

  typedef enum logic [2:0] {
    st_idle,
    st_prefill,
    st_wait_trig,
    st_post,
    st_done
  } state_t;

  state_t            state_q;
  state_t            state_d;
  acq_pkg::acq_evn_t evn_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d    = state_q;
    tmr_load_o = 1'b0;
    tmr_val_o  = pre_len;
    evn_d      = '0;
    if (ctl_i.stp) begin
      // abort from anywhere
      state_d   = st_idle;
      evn_d.stp = 1'b1;
    end else begin
      case (state_q)
        st_idle, st_done: begin
          // start or restart
          if (ctl_i.str) begin
            state_d    = st_prefill;
            tmr_load_o = 1'b1;
            tmr_val_o  = pre_len;
            evn_d.str  = 1'b1;
          end
        end
        st_prefill, st_wait_trig: begin
          // trigger accepted, reload for the post length
          if (trg_ena_o && hit_i) begin
            state_d    = st_post;
            tmr_load_o = 1'b1;
            tmr_val_o  = post_len;
            evn_d.trg  = 1'b1;
          end else if (trg_ena_o) begin
            state_d = st_wait_trig;
          end
        end
        st_post: begin
          // last sample went in on the previous cycle
          if (tmr_zero_i) begin
            state_d   = st_done;
            evn_d.lst = 1'b1;
          end
        end
        default: begin
          state_d = st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q <= st_idle;
      evn_o   <= '0;
    end else begin
      state_q <= state_d;
      evn_o   <= evn_d;
    end
  end

  ////////////////////
  // data path controls
  ////////////////////

  // history full once pre-fill count runs out
  assign trg_ena_o = (state_q == st_wait_trig) || ((state_q == st_prefill) && tmr_zero_i);

  // timer counts pre-fill and post samples
  assign tmr_ena_o = vld_i && ((state_q == st_prefill) || (state_q == st_post));

  // write every sample until the post count is used up
  assign wr_ena_o = vld_i && ((state_q == st_prefill) || (state_q == st_wait_trig) ||
                              ((state_q == st_post) && !tmr_zero_i));

  // freeze on the step into done
  assign freeze_o = (state_q == st_post) && tmr_zero_i;

  // status levels, rd_busy is merged at the top
  assign sts_o.armed   = (state_q == st_prefill) || (state_q == st_wait_trig);
  assign sts_o.trig    = (state_q == st_post) || (state_q == st_done);
  assign sts_o.done    = (state_q == st_done);
  assign sts_o.rd_busy = 1'b0;

endmodule

//--- source/acq_pkg.sv
// types shared by every acquisition block
// widths come from the defines header
// the rsv control bit carries no function and is expected at 0

`include "acq_defines.svh"

package acq_pkg;

  // signed two's complement sample
  typedef logic signed [`ACQ_SMP_W-1:0] smp_t;

  // per channel software control, pulses except lvl_ena
  typedef struct packed {
    logic str;      // software start
    logic stp;      // software stop
    logic trg;      // software trigger
    logic lvl_ena;  // level trigger enable
    logic rsv;      // reserved
  } acq_ctl_t;

  // trigger configuration
  typedef struct packed {
    smp_t level;
  } acq_cfg_t;

  // per channel status levels
  typedef struct packed {
    logic armed;    // pre-fill or waiting for trigger
    logic trig;     // trigger accepted
    logic done;     // window frozen
    logic rd_busy;  // readout handshake in progress
  } acq_sts_t;

  // event pulses
  typedef struct packed {
    logic str;  // start accepted
    logic stp;  // stop accepted
    logic trg;  // trigger accepted
    logic lst;  // last post-trigger sample written
  } acq_evn_t;

  // readout request and response
  typedef struct packed {
    logic req;
  } rd_req_t;

  typedef struct packed {
    logic ack;
    smp_t dat;
  } rd_rsp_t;

endpackage

//--- source/acq_timer.sv
// loadable sample down-counter
// one extra bit over the pointer width so a full depth count fits
// zero_o stays low after reset until the first load

`include "acq_defines.svh"

module acq_timer (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // load a new length
  input  logic                  load_i,
  input  logic [`ACQ_CNT_W:0]   load_val_i,
  // count one sample
  input  logic                  cnt_ena_i,
  output logic                  zero_o
);

  logic [`ACQ_CNT_W:0] cnt;
  logic                loaded;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt    <= '0;
      loaded <= 1'b0;
    end else if (load_i) begin
      cnt    <= load_val_i;
      loaded <= 1'b1;
    end else if (cnt_ena_i && (cnt != '0)) begin
      // saturate at zero
      cnt    <= cnt - 1'b1;
    end
  end

  assign zero_o = loaded && (cnt == '0);

endmodule

//--- source/acq_top.sv
// oscilloscope acquisition path, one slice per ADC channel
// single clock domain, no decimation, ADC stream is never stalled
// channels share nothing but clock and reset

`include "acq_defines.svh"

module acq_top (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // ADC words
  input  logic [`ACQ_CHN-1:0][`ACQ_SMP_W-1:0]     adc_dat_i,
  // software control and trigger level
  input  acq_pkg::acq_ctl_t [`ACQ_CHN-1:0]        ctl_i,
  input  acq_pkg::acq_cfg_t [`ACQ_CHN-1:0]        cfg_i,
  // host readout
  input  acq_pkg::rd_req_t  [`ACQ_CHN-1:0]        rd_req_i,
  output acq_pkg::rd_rsp_t  [`ACQ_CHN-1:0]        rd_rsp_o,
  // status and events
  output acq_pkg::acq_sts_t [`ACQ_CHN-1:0]        sts_o,
  output acq_pkg::acq_evn_t [`ACQ_CHN-1:0]        evn_o
);

  ////////////////////
  // channel slices
  ////////////////////

  for (genvar i = 0; i < `ACQ_CHN; i++) begin : for_chn

    acq_pkg::smp_t       smp;
    logic                vld;
    logic                hit;
    logic                trg_ena;
    logic                tmr_load;
    logic [`ACQ_CNT_W:0] tmr_val;
    logic                tmr_ena;
    logic                tmr_zero;
    logic                wr_ena;
    logic                freeze;
    logic                rd_busy;
    acq_pkg::acq_sts_t   fsm_sts;

    adc_frontend frontend (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .adc_dat_i (adc_dat_i[i]),
      .smp_o     (smp),
      .vld_o     (vld)
    );

    acq_trigger trigger (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .smp_i     (smp),
      .vld_i     (vld),
      .level_i   (cfg_i[i].level),
      .lvl_ena_i (ctl_i[i].lvl_ena),
      .sw_trg_i  (ctl_i[i].trg),
      .ena_i     (trg_ena),
      .hit_o     (hit)
    );

    // one timer serves pre-fill and post lengths
    acq_timer timer (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .load_i     (tmr_load),
      .load_val_i (tmr_val),
      .cnt_ena_i  (tmr_ena),
      .zero_o     (tmr_zero)
    );

    acq_fsm fsm (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .ctl_i      (ctl_i[i]),
      .vld_i      (vld),
      .hit_i      (hit),
      .tmr_zero_i (tmr_zero),
      .tmr_load_o (tmr_load),
      .tmr_val_o  (tmr_val),
      .tmr_ena_o  (tmr_ena),
      .trg_ena_o  (trg_ena),
      .wr_ena_o   (wr_ena),
      .freeze_o   (freeze),
      .sts_o      (fsm_sts),
      .evn_o      (evn_o[i])
    );

    acq_buffer buffer (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .smp_i     (smp),
      .wr_ena_i  (wr_ena),
      .freeze_i  (freeze),
      .rd_req_i  (rd_req_i[i]),
      .rd_rsp_o  (rd_rsp_o[i]),
      .rd_busy_o (rd_busy)
    );

    // readout busy joins the FSM status
    assign sts_o[i] = '{armed:   fsm_sts.armed,
                        trig:    fsm_sts.trig,
                        done:    fsm_sts.done,
                        rd_busy: rd_busy};

  end : for_chn

endmodule

//--- source/acq_trigger.sv
// level crossing and software trigger merge for one channel
// rising crossing only, previous sample below level and current at or above
// hit is combinational on the current sample so it lands on the trigger sample

module acq_trigger (
  input  logic          adc_clk,
  input  logic          top_rst,
  // sample stream
  input  acq_pkg::smp_t smp_i,
  input  logic          vld_i,
  // configuration
  input  acq_pkg::smp_t level_i,
  input  logic          lvl_ena_i,
  // software trigger pulse
  input  logic          sw_trg_i,
  // enable from the FSM
  input  logic          ena_i,
  output logic          hit_o
);

  // previous sample
  acq_pkg::smp_t smp_prv;
  logic          lvl_hit;

  // tracked all the time, so a crossing right at enable is seen
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_prv <= '0;
    end else if (vld_i) begin
      smp_prv <= smp_i;
    end
  end

  // signed compare against the level
  assign lvl_hit = lvl_ena_i && (smp_prv < level_i) && (level_i <= smp_i);

  // merged hit, counted only while enabled
  assign hit_o = ena_i && vld_i && (lvl_hit || sw_trg_i);

endmodule

//--- source/adc_frontend.sv
// one ADC channel input stage
// the ADC delivers negative-slope coding, output is two's complement
// one cycle from raw word to converted sample, no stall possible

`include "acq_defines.svh"

module adc_frontend (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // raw ADC word
  input  logic [`ACQ_SMP_W-1:0]   adc_dat_i,
  // converted stream
  output acq_pkg::smp_t           smp_o,
  output logic                    vld_o
);

  // input register, close to the pads
  logic [`ACQ_SMP_W-1:0] adc_raw;

  always_ff @(posedge adc_clk) begin
    adc_raw <= adc_dat_i;
  end

  // keep sign bit, invert the magnitude bits
  assign smp_o = {adc_raw[`ACQ_SMP_W-1], ~adc_raw[`ACQ_SMP_W-2:0]};

  // stream is valid every cycle once out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= 1'b1;
    end
  end

endmodule

//--- testbench/acq_checker.sv
// readout handshake, status and event checks for every channel
// bound into the acquisition top, quiet while top_rst is high
// failures are reported by the assertions alone

`include "acq_defines.svh"

module acq_checker (
  input logic                                adc_clk,
  input logic                                top_rst,
  input acq_pkg::rd_req_t  [`ACQ_CHN-1:0]    rd_req_i,
  input acq_pkg::rd_rsp_t  [`ACQ_CHN-1:0]    rd_rsp_i,
  input acq_pkg::acq_sts_t [`ACQ_CHN-1:0]    sts_i,
  input acq_pkg::acq_evn_t [`ACQ_CHN-1:0]    evn_i
);

  timeunit 1ns;
  timeprecision 100ps;

  for (genvar i = 0; i < `ACQ_CHN; i++) begin : for_chn

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge adc_clk) disable iff (top_rst)
      $rose(rd_rsp_i[i].ack) |-> $past(rd_req_i[i].req))
      else $error("channel %0d ack rose without req", i);

    // ack holds until the host drops req
    ack_after_req: assert property (@(posedge adc_clk) disable iff (top_rst)
      $fell(rd_rsp_i[i].ack) |-> !$past(rd_req_i[i].req))
      else $error("channel %0d ack fell while req was high", i);

    // frozen and armed exclude each other
    done_not_armed: assert property (@(posedge adc_clk) disable iff (top_rst)
      !(sts_i[i].done && sts_i[i].armed))
      else $error("channel %0d done and armed together", i);

    // event pulses last one cycle
    str_pulse: assert property (@(posedge adc_clk) disable iff (top_rst)
      evn_i[i].str |=> !evn_i[i].str)
      else $error("channel %0d start event longer than a cycle", i);

    trg_pulse: assert property (@(posedge adc_clk) disable iff (top_rst)
      evn_i[i].trg |=> !evn_i[i].trg)
      else $error("channel %0d trigger event longer than a cycle", i);

    lst_pulse: assert property (@(posedge adc_clk) disable iff (top_rst)
      evn_i[i].lst |=> !evn_i[i].lst)
      else $error("channel %0d last event longer than a cycle", i);

  end : for_chn

endmodule

bind acq_top acq_checker checker_i (
  .adc_clk  (adc_clk),
  .top_rst  (top_rst),
  .rd_req_i (rd_req_i),
  .rd_rsp_i (rd_rsp_o),
  .sts_i    (sts_o),
  .evn_i    (evn_o)
);

//--- testbench/acq_tb.sv
// testbench for the multi-channel acquisition path
// one stream process drives ADC words and control pulses on the rising edge
// and steps a software model of the trigger and window rules per channel
// tests change stimulus controls on the falling edge only

`include "acq_defines.svh"

module acq_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_tests   = 6;
  localparam int depth     = `ACQ_BUF_DEPTH;
  localparam int pre_len   = `ACQ_PRE_LEN;
  localparam int wd_cycles = 16 + n_tests * (depth * 8 + 2000);

  logic                                adc_clk = 1'b0;
  logic                                top_rst = 1'b1;
  logic [`ACQ_CHN-1:0][`ACQ_SMP_W-1:0] adc_dat_i = '0;
  acq_pkg::acq_ctl_t [`ACQ_CHN-1:0]    ctl_i = '0;
  acq_pkg::acq_cfg_t [`ACQ_CHN-1:0]    cfg_i = '0;
  acq_pkg::rd_req_t  [`ACQ_CHN-1:0]    rd_req_i = '0;
  acq_pkg::rd_rsp_t  [`ACQ_CHN-1:0]    rd_rsp_o;
  acq_pkg::acq_sts_t [`ACQ_CHN-1:0]    sts_o;
  acq_pkg::acq_evn_t [`ACQ_CHN-1:0]    evn_o;

  // stimulus controls, written by the tests
  int            gen_mode [`ACQ_CHN];  // 0 lfsr, 1 ramp
  int            gen_base [`ACQ_CHN];
  int            gen_step [`ACQ_CHN];
  int            gen_t0   [`ACQ_CHN];
  int            str_at   [`ACQ_CHN];  // cycle of each control pulse
  int            stp_at   [`ACQ_CHN];
  int            trg_at   [`ACQ_CHN];
  logic          lvl_ena  [`ACQ_CHN];
  acq_pkg::smp_t level    [`ACQ_CHN];

  // stream state and model, written by the stream process
  int                    cyc = 0;
  logic [15:0]           lfsr = 16'd63870;
  logic [`ACQ_SMP_W-1:0] prev_word [`ACQ_CHN];
  int                    mst       [`ACQ_CHN];  // 0 idle, 1 armed, 2 post, 3 done
  int                    n_rec     [`ACQ_CHN];
  int                    win_cnt   [`ACQ_CHN];
  int                    n_trg     [`ACQ_CHN];  // triggers accepted
  int                    n_win     [`ACQ_CHN];  // windows completed
  acq_pkg::smp_t         prev_smp  [`ACQ_CHN];
  acq_pkg::smp_t         ring      [`ACQ_CHN][pre_len];
  acq_pkg::smp_t         win       [`ACQ_CHN][depth];

  // event pulses seen on the DUT
  int trg_seen [`ACQ_CHN];
  int lst_seen [`ACQ_CHN];

  int    err_cnt  = 0;
  int    test_cnt = 0;
  int    test_err = 0;
  string test_name;

  acq_top uut (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .ctl_i     (ctl_i),
    .cfg_i     (cfg_i),
    .rd_req_i  (rd_req_i),
    .rd_rsp_o  (rd_rsp_o),
    .sts_o     (sts_o),
    .evn_o     (evn_o)
  );

  always #5 adc_clk = ~adc_clk;

  ////////////////////
  // reference model
  ////////////////////

  // negative slope code, sign kept and magnitude bits flipped, its own inverse
  function automatic acq_pkg::smp_t adc_to_smp(input logic [`ACQ_SMP_W-1:0] raw);
    logic [`ACQ_SMP_W-1:0] mag_mask;
    mag_mask = {1'b0, {(`ACQ_SMP_W-1){1'b1}}};
    return raw ^ mag_mask;
  endfunction

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one sample of one channel, in stream order
  task automatic model_step(input int ch, input acq_pkg::smp_t s,
                            input acq_pkg::acq_ctl_t ctl, input acq_pkg::smp_t lvl);
    logic hit;
    hit = ctl.trg || (ctl.lvl_ena && (prev_smp[ch] < lvl) && (lvl <= s));
    if (ctl.stp) begin
      mst[ch] = 0;
    end else if ((mst[ch] == 0) || (mst[ch] == 3)) begin
      if (ctl.str) begin
        mst[ch]     = 1;
        n_rec[ch]   = 0;
        win_cnt[ch] = 0;
      end
    end else if (mst[ch] == 1) begin
      // trigger counts only once the history is full
      if ((n_rec[ch] >= pre_len) && hit) begin
        for (int i = 0; i < pre_len; i++) begin
          win[ch][i] = ring[ch][(n_rec[ch] + i) % pre_len];
        end
        win[ch][pre_len] = s;
        win_cnt[ch]      = pre_len + 1;
        mst[ch]          = 2;
        n_trg[ch]++;
      end else begin
        ring[ch][n_rec[ch] % pre_len] = s;
        n_rec[ch]++;
      end
    end else begin
      win[ch][win_cnt[ch]] = s;
      win_cnt[ch]++;
      if (win_cnt[ch] == depth) begin
        mst[ch] = 3;
        n_win[ch]++;
      end
    end
    prev_smp[ch] = s;
  endtask

  ////////////////////
  // stream driver
  ////////////////////

  always @(posedge adc_clk) begin : stream
    acq_pkg::acq_ctl_t     ctl;
    acq_pkg::smp_t         ramp;
    logic [`ACQ_SMP_W-1:0] word;
    for (int ch = 0; ch < `ACQ_CHN; ch++) begin
      ctl         = '0;
      ctl.str     = (cyc == str_at[ch]);
      ctl.stp     = (cyc == stp_at[ch]);
      ctl.trg     = (cyc == trg_at[ch]);
      ctl.lvl_ena = lvl_ena[ch];
      // the DUT shows last cycle's word as this cycle's sample
      if (top_rst) begin
        mst[ch] = 0;
      end else begin
        model_step(ch, adc_to_smp(prev_word[ch]), ctl, level[ch]);
      end
      if (gen_mode[ch] == 0) begin
        for (int b = 0; b < `ACQ_SMP_W; b++) begin
          word = {word[`ACQ_SMP_W-2:0], lfsr[0]};
          lfsr = lfsr_next(lfsr);
        end
      end else begin
        ramp = acq_pkg::smp_t'(gen_base[ch] + gen_step[ch] * (cyc - gen_t0[ch]));
        word = adc_to_smp(ramp);
      end
      prev_word[ch]      = word;
      adc_dat_i[ch]     <= word;
      ctl_i[ch]         <= ctl;
      cfg_i[ch].level   <= level[ch];
    end
    cyc++;
  end

  // accepted trigger and last-sample pulses per channel
  always @(negedge adc_clk) begin
    for (int ch = 0; ch < `ACQ_CHN; ch++) begin
      if (evn_o[ch].trg) begin
        trg_seen[ch]++;
      end
      if (evn_o[ch].lst) begin
        lst_seen[ch]++;
      end
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
      test_err++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err  = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    if (test_err != 0) begin
      err_cnt++;
    end
    $display("%s %s", test_name, (test_err == 0) ? "passed" : "failed");
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge adc_clk);
  endtask

  // ramp of converted samples from the next rising edge on, step 0 holds
  task automatic set_ramp(input int ch, input int base, input int step);
    gen_mode[ch] = 1;
    gen_base[ch] = base;
    gen_step[ch] = step;
    gen_t0[ch]   = cyc;
  endtask

  task automatic start_acq(input int ch);
    str_at[ch] = cyc;
    idle(2);
  endtask

  task automatic wait_done(input int ch);
    int n;
    n = 0;
    while (!sts_o[ch].done && (n < 2000)) begin
      @(negedge adc_clk);
      n++;
    end
    if (!sts_o[ch].done) begin
      $display("%s: channel %0d never reached done", test_name, ch);
      test_err++;
    end
    // lst pulses in the first done cycle
    @(negedge adc_clk);
    check_value($sformatf("ch%0d model window complete", ch), 3, mst[ch]);
    check_value($sformatf("ch%0d trig status", ch), 1, sts_o[ch].trig);
    check_value($sformatf("ch%0d trigger events", ch), n_trg[ch], trg_seen[ch]);
    check_value($sformatf("ch%0d last events", ch), n_win[ch], lst_seen[ch]);
  endtask

  task automatic wait_ack(input int ch, input logic lvl, output logic ok);
    int n;
    n = 0;
    do begin
      @(negedge adc_clk);
      n++;
    end while ((rd_rsp_o[ch].ack !== lvl) && (n < 20));
    ok = (rd_rsp_o[ch].ack === lvl);
  endtask

  // four-phase reads of window samples first .. first+count-1
  task automatic read_window(input int ch, input int first, input int count);
    logic ok;
    for (int i = first; i < first + count; i++) begin
      @(posedge adc_clk);
      rd_req_i[ch].req <= 1'b1;
      wait_ack(ch, 1'b1, ok);
      if (!ok) begin
        $display("%s: channel %0d gave no ack on read %0d", test_name, ch, i);
        test_err++;
        return;
      end
      check_value($sformatf("ch%0d sample %0d", ch, i), win[ch][i], rd_rsp_o[ch].dat);
      check_value($sformatf("ch%0d busy on read %0d", ch, i), 1, sts_o[ch].rd_busy);
      @(posedge adc_clk);
      rd_req_i[ch].req <= 1'b0;
      wait_ack(ch, 1'b0, ok);
      if (!ok) begin
        $display("%s: channel %0d held ack after read %0d", test_name, ch, i);
        test_err++;
        return;
      end
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    for (int ch = 0; ch < `ACQ_CHN; ch++) begin
      gen_mode[ch] = 0;
      gen_base[ch] = 0;
      gen_step[ch] = 0;
      gen_t0[ch]   = 0;
      str_at[ch]   = -1;
      stp_at[ch]   = -1;
      trg_at[ch]   = -1;
      lvl_ena[ch]  = 1'b0;
      level[ch]    = '0;
      n_trg[ch]    = 0;
      n_win[ch]    = 0;
      trg_seen[ch] = 0;
      lst_seen[ch] = 0;
    end
    repeat (16) @(posedge adc_clk);
    top_rst <= 1'b0;

    begin_test("reset");
    for (int k = 0; k < 10; k++) begin
      @(negedge adc_clk);
      check_value("sts", 0, sts_o);
      check_value("evn", 0, evn_o);
      check_value("ack", 0, {rd_rsp_o[1].ack, rd_rsp_o[0].ack});
    end
    end_test();

    // level trigger, lfsr data then a ramp through the level
    begin_test("level");
    level[0]   = 16'sd1000;
    lvl_ena[0] = 1'b1;
    start_acq(0);
    idle(40);
    set_ramp(0, -2000, 50);
    wait_done(0);
    read_window(0, 0, depth);
    end_test();

    // software trigger while waiting, level trigger off
    begin_test("sw_trig");
    lvl_ena[1] = 1'b0;
    start_acq(1);
    idle(30);
    trg_at[1] = cyc;
    wait_done(1);
    read_window(1, 0, depth);
    end_test();

    // crossing during pre-fill is ignored
    begin_test("holdoff");
    level[0] = '0;
    set_ramp(0, -20000, 0);
    idle(4);
    start_acq(0);
    set_ramp(0, 20000, 0);
    idle(5);
    set_ramp(0, -20000, 0);
    idle(25);
    set_ramp(0, -300, 7);
    wait_done(0);
    // first sample at or above zero on that ramp
    check_value("trigger sample", 1, win[0][pre_len]);
    read_window(0, 0, depth);
    end_test();

    // stop while waiting, then a fresh capture
    begin_test("stop");
    set_ramp(0, -20000, 0);
    start_acq(0);
    idle(30);
    check_value("armed before stop", 1, sts_o[0].armed);
    stp_at[0] = cyc;
    idle(3);
    check_value("armed after stop", 0, sts_o[0].armed);
    check_value("done after stop", 0, sts_o[0].done);
    set_ramp(0, -500, 9);
    start_acq(0);
    wait_done(0);
    read_window(0, 0, depth);
    end_test();

    // both channels at once, interleaved readout
    begin_test("two_chn");
    level[0]   = 16'sd5000;
    set_ramp(0, -3000, 40);
    level[1]   = -16'sd7000;
    lvl_ena[1] = 1'b1;
    str_at[0]  = cyc;
    str_at[1]  = cyc;
    idle(2);
    wait_done(0);
    wait_done(1);
    read_window(0, 0, depth / 2);
    read_window(1, 0, depth);
    read_window(0, depth / 2, depth / 2);
    end_test();

    $display("tests run %0d, tests failed %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog sized from the test count
  initial begin
    repeat (wd_cycles) @(posedge adc_clk);
    $display("timeout: tests did not complete within %0d cycles", wd_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
